//--- rv_core_pkg.sv
// rv32i core shared types
`default_nettype none

package rv_core_pkg;

  // major opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011
  } opcode_t;

  typedef enum logic [3:0] {
    st_idle, st_fetch, st_fetch_wait, st_decode,
    st_reg_reg, st_reg_imm, st_lui, st_auipc,
    st_jal, st_branch, st_jalr, st_load,
    st_load_wait, st_store, st_store_wait, st_halt
  } ctrl_state_t;

  // encoded in funct3 order so op and op_imm pass funct3 straight through
  typedef enum logic [2:0] {
    alu_add, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_alu, wb_memory, wb_pc_plus_4
  } wb_src_t;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry_out;
    logic overflow;
  } alu_flags_t;

  typedef struct packed {
    // 1 selects pc
    logic    alua_src;
    // 1 selects immediate
    logic    alub_src;
    alu_op_t alu_op;
    logic    sub;
    logic    arithmetic;
    // 1 takes the jump target from the alu (jalr)
    logic    alupc_src;
    logic    pc_src;
    logic    pc_en;
    wb_src_t wb_src;
    logic    wr_reg_en;
    logic    ir_en;
    logic    mem_addr_src;
  } ctrl_t;

  typedef struct packed {
    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
  } decode_t;

endpackage

`default_nettype wire

//--- alu.sv
// 32-bit alu with flags
`timescale 1ns/100ps
`default_nettype none

module alu
  import rv_core_pkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_t     op,
  input  logic        sub,
  input  logic        arithmetic,
  output logic [31:0] result,
  output alu_flags_t  flags
);

  logic [31:0] b_eff;
  logic [32:0] sum;
  logic [32:0] diff;
  logic        diff_ovf;
  logic [4:0]  shamt;
  logic [31:0] sra_result;

  // sub turns the adder into a - b
  assign b_eff = sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub};

  // slt and sltu compare regardless of sub
  assign diff     = {1'b0, a} + {1'b0, ~b} + 33'd1;
  assign diff_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

  assign shamt      = b[4:0];
  assign sra_result = $signed(a) >>> shamt;

  always_comb begin
    case (op)
      alu_add:  result = sum[31:0];
      alu_sll:  result = a << shamt;
      alu_slt:  result = {31'b0, diff[31] ^ diff_ovf};
      alu_sltu: result = {31'b0, ~diff[32]};
      alu_xor:  result = a ^ b;
      alu_srl:  result = arithmetic ? sra_result : a >> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = sum[31:0];
    endcase
  end

  assign flags.zero      = (sum[31:0] == 32'b0);
  assign flags.negative  = sum[31];
  assign flags.carry_out = sum[32];
  assign flags.overflow  = (a[31] == b_eff[31]) && (sum[31] != a[31]);

endmodule

`default_nettype wire

//--- register_file.sv
// 32 x 32 register file
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data,
  input  logic        wr_en,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  // x0 is never written, so it stays at its reset value of zero
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (wr_en && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

//--- control_unit.sv
// multicycle control unit
`timescale 1ns/100ps
`default_nettype none

module control_unit
  import rv_core_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_busy,
  input  decode_t     decode,
  input  alu_flags_t  flags,
  output logic        mem_rd_en,
  output logic        mem_wr_en,
  output logic [3:0]  mem_byte_en,
  output ctrl_t       ctrl,
  output logic        halted
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  logic        cond;
  logic        branch_taken;
  logic [3:0]  width_byte_en;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // funct3[0] inverts beq/blt/bltu into bne/bge/bgeu
  assign cond = decode.funct3[2] ?
                (decode.funct3[1] ? ~flags.carry_out : flags.negative ^ flags.overflow) :
                flags.zero;
  assign branch_taken = cond ^ decode.funct3[0];

  // access width, always from the low lanes
  always_comb begin
    case (decode.funct3[1:0])
      2'b00:   width_byte_en = 4'b0001;
      2'b01:   width_byte_en = 4'b0011;
      default: width_byte_en = 4'b1111;
    endcase
  end

  always_comb begin
    next_state  = state;
    mem_rd_en   = 1'b0;
    mem_wr_en   = 1'b0;
    mem_byte_en = 4'b0000;
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.wb_src = wb_alu;

    case (state)
      st_idle: next_state = st_fetch;

      st_fetch: begin
        mem_rd_en   = 1'b1;
        mem_byte_en = 4'b1111;
        if (mem_busy) next_state = st_fetch_wait;
      end

      st_fetch_wait: begin
        mem_byte_en = 4'b1111;
        mem_rd_en   = mem_busy;
        if (!mem_busy) begin
          ctrl.ir_en = 1'b1;
          next_state = st_decode;
        end
      end

      st_decode: begin
        case (decode.opcode)
          opc_op:     next_state = st_reg_reg;
          opc_op_imm: next_state = st_reg_imm;
          opc_lui:    next_state = st_lui;
          opc_auipc:  next_state = st_auipc;
          opc_jal:    next_state = st_jal;
          opc_jalr:   next_state = st_jalr;
          opc_branch: next_state = st_branch;
          opc_load:   next_state = st_load;
          opc_store:  next_state = st_store;
          default:    next_state = st_halt;
        endcase
      end

      st_reg_reg: begin
        ctrl.alu_op     = alu_op_t'(decode.funct3);
        ctrl.sub        = decode.funct7_5;
        ctrl.arithmetic = decode.funct7_5;
        ctrl.wr_reg_en  = 1'b1;
        ctrl.pc_en      = 1'b1;
        next_state      = st_fetch;
      end

      st_reg_imm: begin
        ctrl.alub_src   = 1'b1;
        ctrl.alu_op     = alu_op_t'(decode.funct3);
        // only srai carries funct7 bit 5 in its immediate
        ctrl.arithmetic = decode.funct7_5 & (decode.funct3 == 3'b101);
        ctrl.wr_reg_en  = 1'b1;
        ctrl.pc_en      = 1'b1;
        next_state      = st_fetch;
      end

      st_lui, st_auipc: begin
        ctrl.alua_src  = (state == st_auipc);
        ctrl.alub_src  = 1'b1;
        ctrl.wr_reg_en = 1'b1;
        ctrl.pc_en     = 1'b1;
        next_state     = st_fetch;
      end

      st_jal, st_jalr: begin
        ctrl.alub_src  = 1'b1;
        ctrl.alupc_src = (state == st_jalr);
        ctrl.pc_src    = 1'b1;
        ctrl.wb_src    = wb_pc_plus_4;
        ctrl.wr_reg_en = 1'b1;
        ctrl.pc_en     = 1'b1;
        next_state     = st_fetch;
      end

      st_branch: begin
        ctrl.sub    = 1'b1;
        ctrl.pc_src = branch_taken;
        ctrl.pc_en  = 1'b1;
        next_state  = st_fetch;
      end

      st_load, st_load_wait: begin
        ctrl.mem_addr_src = 1'b1;
        ctrl.alub_src     = 1'b1;
        ctrl.wb_src       = wb_memory;
        mem_byte_en       = width_byte_en;
        if (state == st_load) begin
          mem_rd_en = 1'b1;
          if (mem_busy) next_state = st_load_wait;
        end else begin
          mem_rd_en = mem_busy;
          if (!mem_busy) begin
            ctrl.wr_reg_en = 1'b1;
            ctrl.pc_en     = 1'b1;
            next_state     = st_fetch;
          end
        end
      end

      st_store, st_store_wait: begin
        ctrl.mem_addr_src = 1'b1;
        ctrl.alub_src     = 1'b1;
        mem_byte_en       = width_byte_en;
        if (state == st_store) begin
          mem_wr_en = 1'b1;
          if (mem_busy) next_state = st_store_wait;
        end else begin
          mem_wr_en = mem_busy;
          if (!mem_busy) begin
            ctrl.pc_en = 1'b1;
            next_state = st_fetch;
          end
        end
      end

      st_halt: next_state = st_halt;

      default: next_state = st_halt;
    endcase
  end

  assign halted = (state == st_halt);

endmodule

`default_nettype wire

//--- datapath.sv
// shared multicycle datapath
`timescale 1ns/100ps
`default_nettype none

module datapath
  import rv_core_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  ctrl_t       ctrl,
  input  logic [31:0] mem_rdata,
  output decode_t     decode,
  output alu_flags_t  flags,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata
);

  logic [31:0] pc;
  logic [31:0] ir;
  logic [31:0] pc_plus_4;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm;
  logic [4:0]  rs1_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [31:0] branch_target;
  logic [31:0] next_pc;
  logic [31:0] load_data;
  logic [31:0] wb_data;
  opcode_t     opcode;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc <= RESET_PC;
      ir <= 32'b0;
    end else begin
      if (ctrl.pc_en) pc <= next_pc;
      if (ctrl.ir_en) ir <= mem_rdata;
    end
  end

  assign opcode          = opcode_t'(ir[6:0]);
  assign decode.opcode   = opcode;
  assign decode.funct3   = ir[14:12];
  assign decode.funct7_5 = ir[30];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  always_comb begin
    case (opcode)
      opc_store:          imm = imm_s;
      opc_branch:         imm = imm_b;
      opc_lui, opc_auipc: imm = imm_u;
      opc_jal:            imm = imm_j;
      default:            imm = imm_i;
    endcase
  end

  // lui reuses rs1 + imm with rs1 forced to x0
  assign rs1_addr = (opcode == opc_lui) ? 5'd0 : ir[19:15];

  register_file u_register_file (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (ir[24:20]),
    .rd_addr  (ir[11:7]),
    .rd_data  (wb_data),
    .wr_en    (ctrl.wr_reg_en),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = ctrl.alua_src ? pc : rs1_data;
  assign alu_b = ctrl.alub_src ? imm : rs2_data;

  alu u_alu (
    .a          (alu_a),
    .b          (alu_b),
    .op         (ctrl.alu_op),
    .sub        (ctrl.sub),
    .arithmetic (ctrl.arithmetic),
    .result     (alu_result),
    .flags      (flags)
  );

  assign pc_plus_4     = pc + 32'd4;
  assign branch_target = pc + imm;
  assign next_pc = !ctrl.pc_src   ? pc_plus_4 :
                   ctrl.alupc_src ? {alu_result[31:1], 1'b0} : branch_target;

  always_comb begin
    case (decode.funct3)
      3'b000:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
      3'b001:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
      3'b100:  load_data = {24'b0, mem_rdata[7:0]};
      3'b101:  load_data = {16'b0, mem_rdata[15:0]};
      default: load_data = mem_rdata;
    endcase
  end

  always_comb begin
    case (ctrl.wb_src)
      wb_memory:    wb_data = load_data;
      wb_pc_plus_4: wb_data = pc_plus_4;
      default:      wb_data = alu_result;
    endcase
  end

  assign mem_addr  = ctrl.mem_addr_src ? alu_result : pc;
  assign mem_wdata = rs2_data;

endmodule

`default_nettype wire

//--- rv_core.sv
// rv32i multicycle core
`timescale 1ns/100ps
`default_nettype none

module rv_core
  import rv_core_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_busy,
  input  logic [31:0] mem_rdata,
  output logic        mem_rd_en,
  output logic        mem_wr_en,
  output logic [3:0]  mem_byte_en,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic        halted
);

  ctrl_t      ctrl;
  decode_t    decode;
  alu_flags_t flags;

  control_unit u_control_unit (
    .clock       (clock),
    .reset       (reset),
    .mem_busy    (mem_busy),
    .decode      (decode),
    .flags       (flags),
    .mem_rd_en   (mem_rd_en),
    .mem_wr_en   (mem_wr_en),
    .mem_byte_en (mem_byte_en),
    .ctrl        (ctrl),
    .halted      (halted)
  );

  datapath #(
    .RESET_PC (RESET_PC)
  ) u_datapath (
    .clock     (clock),
    .reset     (reset),
    .ctrl      (ctrl),
    .mem_rdata (mem_rdata),
    .decode    (decode),
    .flags     (flags),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

endmodule

`default_nettype wire

//--- rv_core_assertions.sv
// memory protocol and halt assertions
`timescale 1ns/100ps
`default_nettype none

module rv_core_assertions (
  input logic       clock,
  input logic       reset,
  input logic       mem_busy,
  input logic       mem_rd_en,
  input logic       mem_wr_en,
  input logic [3:0] mem_byte_en,
  input logic       mem_addr_src,
  input logic       halted
);

  a_reset_quiet: assert property (@(posedge clock)
    reset |-> !mem_rd_en && !mem_wr_en && !halted)
    else $error("memory enable or halted active during reset");

  a_one_enable: assert property (@(posedge clock) disable iff (reset)
    !(mem_rd_en && mem_wr_en))
    else $error("read and write enable high together");

  // address source and width must hold for the whole access
  a_addr_stable: assert property (@(posedge clock) disable iff (reset)
    mem_busy && $past(mem_busy) |-> $stable(mem_byte_en) && $stable(mem_addr_src))
    else $error("access changed while memory busy");

  a_halt_quiet: assert property (@(posedge clock) disable iff (reset)
    halted |-> !mem_rd_en && !mem_wr_en ##1 halted)
    else $error("memory access or exit after halt");

endmodule

bind control_unit rv_core_assertions u_assertions (
  .clock        (clock),
  .reset        (reset),
  .mem_busy     (mem_busy),
  .mem_rd_en    (mem_rd_en),
  .mem_wr_en    (mem_wr_en),
  .mem_byte_en  (mem_byte_en),
  .mem_addr_src (ctrl.mem_addr_src),
  .halted       (halted)
);

`default_nettype wire

//--- rv_core_tb.sv
// rv32i core testbench
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb
  import rv_core_pkg::*;
;

  localparam logic [31:0] RESET_PC = 32'h0000_0100;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
  } store_t;

  logic        clock;
  logic        reset;
  logic        mem_busy = 1'b0;
  logic [31:0] mem_rdata = 32'b0;
  logic        mem_rd_en;
  logic        mem_wr_en;
  logic [3:0]  mem_byte_en;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        halted;

  logic [31:0] seed = 32'd23495;
  logic [31:0] mem [1024];
  logic [31:0] ref_mem [1024];
  logic [31:0] ref_regs [32];
  logic [31:0] prog [256];
  int          prog_len;
  logic [31:0] sec_b;
  logic [31:0] sec_c;
  logic [31:0] exp_reads [$];
  logic [31:0] dut_reads [$];
  store_t      exp_st [$];
  store_t      dut_st [$];
  int          exp_tag [$];
  logic [3:0]  first_be;
  int          n_exec;
  int          limit = 1 << 30;
  int          cycles = 0;
  int          errors [5];
  string       test_names [5] = '{"reset", "arithmetic", "load_store", "control_flow", "halt"};

  rv_core #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clock       (clock),
    .reset       (reset),
    .mem_busy    (mem_busy),
    .mem_rdata   (mem_rdata),
    .mem_rd_en   (mem_rd_en),
    .mem_wr_en   (mem_wr_en),
    .mem_byte_en (mem_byte_en),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .halted      (halted)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] hi;
    seed = seed * 32'd1103515245 + 32'd12345;
    hi   = {16'b0, seed[31:16]};
    seed = seed * 32'd1103515245 + 32'd12345;
    return {hi[15:0], seed[31:16]};
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [31:0] v;
    v = 32'd1 + next_rand() % 32'd15;
    return v[4:0];
  endfunction

  task automatic check_equal(input int id, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", test_names[id], exp, act);
      errors[id]++;
    end
  endtask

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a, b,
                                          input logic alt);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // instruction-level interpreter that stops at the first unsupported opcode
  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] npc;
    logic [31:0] im_i;
    logic [31:0] im_s;
    logic [31:0] im_b;
    logic [31:0] w;
    logic [3:0]  be;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr;
    logic        take;
    logic        done;
    store_t      rec;
    pc   = RESET_PC;
    done = 1'b0;
    while (!done) begin
      ir   = ref_mem[pc[11:2]];
      exp_reads.push_back(pc);
      n_exec++;
      f3   = ir[14:12];
      rd   = ir[11:7];
      a    = ref_regs[ir[19:15]];
      b    = ref_regs[ir[24:20]];
      im_i = {{20{ir[31]}}, ir[31:20]};
      im_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      im_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      npc  = pc + 32'd4;
      wr   = 1'b1;
      res  = 32'b0;
      case (ir[6:0])
        opc_op:     res = alu_ref(f3, a, b, ir[30]);
        opc_op_imm: res = alu_ref(f3, a, im_i, ir[30] && f3 == 3'd5);
        opc_lui:    res = {ir[31:12], 12'b0};
        opc_auipc:  res = pc + {ir[31:12], 12'b0};
        opc_jal: begin
          res = pc + 32'd4;
          npc = pc + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        end
        opc_jalr: begin
          res = pc + 32'd4;
          npc = (a + im_i) & ~32'd1;
        end
        opc_branch: begin
          wr = 1'b0;
          case (f3)
            3'd0:    take = (a == b);
            3'd1:    take = (a != b);
            3'd4:    take = ($signed(a) < $signed(b));
            3'd5:    take = ($signed(a) >= $signed(b));
            3'd6:    take = (a < b);
            default: take = (a >= b);
          endcase
          if (take) npc = pc + im_b;
        end
        opc_load: begin
          exp_reads.push_back(a + im_i);
          w = ref_mem[10'((a + im_i) >> 2)];
          case (f3)
            3'd0:    res = {{24{w[7]}}, w[7:0]};
            3'd1:    res = {{16{w[15]}}, w[15:0]};
            3'd4:    res = {24'b0, w[7:0]};
            3'd5:    res = {16'b0, w[15:0]};
            default: res = w;
          endcase
        end
        opc_store: begin
          wr = 1'b0;
          be = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
          rec.addr = a + im_s;
          rec.data = b;
          rec.be   = be;
          exp_st.push_back(rec);
          exp_tag.push_back((pc < sec_b) ? 1 : (pc < sec_c) ? 2 : 3);
          w = ref_mem[rec.addr[11:2]];
          for (int k = 0; k < 4; k++) begin
            if (be[k]) w[8*k +: 8] = b[8*k +: 8];
          end
          ref_mem[rec.addr[11:2]] = w;
        end
        default: done = 1'b1;
      endcase
      if (!done) begin
        if (wr && rd != 5'd0) ref_regs[rd] = res;
        pc = npc;
      end
    end
  endtask

  task automatic build_program();
    logic [31:0] v;
    logic [31:0] sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [2:0]  load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    prog_len = 0;
    for (int r = 1; r < 16; r++) begin
      v = next_rand();
      emit({v[31:12], r[4:0], opc_lui});
    end
    for (int n = 0; n < 25; n++) begin
      v   = next_rand();
      sel = next_rand() % 32'd4;
      rd  = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      f3  = v[2:0];
      if (sel == 32'd0) begin
        emit(enc_r((v[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
      end else if (sel == 32'd1) begin
        // shifts keep the upper immediate bits clear except for srai
        if (f3 == 3'd1) imm = {7'h00, v[8:4]};
        else if (f3 == 3'd5) imm = {v[3] ? 7'h20 : 7'h00, v[8:4]};
        else imm = v[15:4];
        emit(enc_i(imm, rs1, f3, rd, opc_op_imm));
      end else begin
        emit({v[31:12], rd, (sel == 32'd2) ? opc_lui : opc_auipc});
      end
    end
    for (int r = 1; r < 16; r++) begin
      emit(enc_s(12'h400 + 12'(4 * r), r[4:0], 5'd0, 3'd2));
    end
    sec_b = RESET_PC + 32'(prog_len * 4);
    for (int k = 0; k < 8; k++) begin
      v   = next_rand();
      sel = next_rand() % 32'd5;
      emit({v[31:12], 5'd20, opc_lui});
      emit(enc_i(v[11:0], 5'd20, 3'd0, 5'd20, opc_op_imm));
      f3 = 3'(next_rand() % 32'd3);
      emit(enc_s(12'h500 + 12'(4 * k), 5'd20, 5'd0, f3));
      emit(enc_i(12'h500 + 12'(4 * k), 5'd0, load_f3[sel], 5'd21, opc_load));
      emit(enc_s(12'h600 + 12'(4 * k), 5'd21, 5'd0, 3'd2));
    end
    sec_c = RESET_PC + 32'(prog_len * 4);
    for (int j = 0; j < 6; j++) begin
      rs1 = pick_reg();
      rs2 = (next_rand() % 32'd3 == 32'd0) ? rs1 : pick_reg();
      emit(enc_b(13'd8, rs2, rs1, br_f3[j]));
      emit(enc_i(12'(1 << j), 5'd25, 3'd0, 5'd25, opc_op_imm));
    end
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd22, opc_jal});
    emit(enc_i(12'd64, 5'd25, 3'd0, 5'd25, opc_op_imm));
    emit(enc_s(12'h700, 5'd22, 5'd0, 3'd2));
    emit({20'd0, 5'd23, opc_auipc});
    emit(enc_i(12'd12, 5'd23, 3'd0, 5'd24, opc_jalr));
    emit(enc_i(12'd128, 5'd25, 3'd0, 5'd25, opc_op_imm));
    emit(enc_s(12'h704, 5'd24, 5'd0, 3'd2));
    emit(enc_s(12'h708, 5'd25, 5'd0, 3'd2));
    // all-zero word has no valid opcode
    emit(32'h0000_0000);
  endtask

  // memory model with 1 to 4 busy cycles per access
  always @(posedge clock) begin
    logic        s_reset;
    logic        s_rd;
    logic        s_wr;
    logic [31:0] s_addr;
    logic [31:0] s_wd;
    logic [3:0]  s_be;
    logic [31:0] w;
    store_t      rec;
    int          cnt;
    s_reset = reset;
    s_rd    = mem_rd_en;
    s_wr    = mem_wr_en;
    s_addr  = mem_addr;
    s_wd    = mem_wdata;
    s_be    = mem_byte_en;
    #2;
    if (s_reset) begin
      mem_busy = 1'b0;
      cnt      = 0;
    end else if (mem_busy) begin
      if (cnt <= 1) begin
        mem_busy = 1'b0;
        if (s_wr) begin
          rec.addr = s_addr;
          rec.data = s_wd;
          rec.be   = s_be;
          dut_st.push_back(rec);
          w = mem[s_addr[11:2]];
          for (int k = 0; k < 4; k++) begin
            if (s_be[k]) w[8*k +: 8] = s_wd[8*k +: 8];
          end
          mem[s_addr[11:2]] = w;
        end else begin
          mem_rdata = mem[s_addr[11:2]];
        end
      end else begin
        cnt--;
      end
    end else if (s_rd || s_wr) begin
      mem_busy = 1'b1;
      cnt      = 1 + int'(next_rand() % 32'd4);
      if (s_rd) begin
        if (dut_reads.size() == 0) first_be = s_be;
        dut_reads.push_back(s_addr);
      end
    end
  end

  initial begin
    while (cycles <= limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: the core did not halt within %0d cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int quiet_err;
    int total;
    int id;
    reset = 1'b1;
    for (int i = 0; i < 1024; i++) begin
      mem[i]     = (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++) ref_regs[i] = 32'b0;
    build_program();
    for (int i = 0; i < prog_len; i++) begin
      mem[int'(RESET_PC[11:2]) + i]     = prog[i];
      ref_mem[int'(RESET_PC[11:2]) + i] = prog[i];
    end
    run_model();
    // fetch, decode, execute and a memory access with the longest busy, plus margin
    limit = 16 + n_exec * 20 + 200;

    repeat (16) begin
      @(posedge clock);
      check_equal(0, 32'd0, {29'b0, mem_rd_en, mem_wr_en, halted});
    end
    #2 reset = 1'b0;
    while (!halted) @(posedge clock);
    check_equal(0, RESET_PC, (dut_reads.size() > 0) ? dut_reads[0] : 32'hFFFF_FFFF);
    check_equal(0, 32'hF, {28'b0, first_be});
    $display("test %s done, %0d errors", test_names[0], errors[0]);

    check_equal(3, exp_st.size(), dut_st.size());
    for (int i = 0; i < exp_st.size() && i < dut_st.size(); i++) begin
      id = exp_tag[i];
      check_equal(id, exp_st[i].addr, dut_st[i].addr);
      check_equal(id, exp_st[i].data, dut_st[i].data);
      check_equal(id, {28'b0, exp_st[i].be}, {28'b0, dut_st[i].be});
    end
    check_equal(3, exp_reads.size(), dut_reads.size());
    for (int i = 0; i < exp_reads.size() && i < dut_reads.size(); i++) begin
      check_equal(3, exp_reads[i], dut_reads[i]);
    end
    for (int t = 1; t < 4; t++) $display("test %s done, %0d errors", test_names[t], errors[t]);

    quiet_err = 0;
    repeat (40) begin
      @(posedge clock);
      if (mem_rd_en || mem_wr_en || !halted) begin
        if (quiet_err == 0) begin
          $display("halt: memory enable seen or halted dropped after the core halted");
        end
        quiet_err++;
      end
    end
    if (quiet_err != 0) errors[4]++;
    $display("test %s done, %0d errors", test_names[4], errors[4]);

    total = 0;
    foreach (errors[t]) total += errors[t];
    $display("%0d tests, %0d errors, %0d instructions, %0d cycles", 5, total, n_exec, cycles);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
rv_core_pkg.sv
alu.sv
register_file.sv
control_unit.sv
datapath.sv
rv_core.sv
rv_core_assertions.sv
rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o sim_rv_core \
  && ./obj_dir/sim_rv_core > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "ALL CHECKS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
